// ==== include/snake_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// Snake game configuration
// Grid, tile, body length, animation rate and colour constants that
// are shared by the RTL blocks of the snake game.
//////////////////////////////////////////////////////////////////////
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// playfield in tiles, 160 x 120 pixels in all
`define SCREEN_TILES_X 16
`define SCREEN_TILES_Y 12
`define TILE_SIZE 10

// segment 0 is the head
`define SNAKE_LENGTH 6
// nearer segments are not checked so a reversal is no hit
`define HIT_FIRST_SEGMENT 4

// animation tick every 2^TICK_WIDTH clocks
`define TICK_WIDTH 20

`define APPLE_TILE_X 3
`define APPLE_TILE_Y 3
`define APPLE_COLOUR 3'b100
`define ERASE_COLOUR 3'b000

// head start tile, body straight below it
`define START_TILE_X 8
`define START_TILE_Y 6

`endif

// ==== src/snakePkg.sv ====
//////////////////////////////////////////////////////////////////////
// Snake game types
// Pixel and tile coordinates, heading and frame sequencer states.
//////////////////////////////////////////////////////////////////////
package snakePkg;

    // screen coordinates, 160 x 120
    typedef logic [7:0] pixelX;
    typedef logic [6:0] pixelY;

    // tile coordinates, 16 x 12
    typedef logic [3:0] tileX;
    typedef logic [3:0] tileY;

    typedef struct packed {
        tileX x;
        tileY y;
    } tilePos;

    // order follows the key priority
    typedef enum logic [1:0] {
        dirRight = 2'd0,
        dirDown  = 2'd1,
        dirUp    = 2'd2,
        dirLeft  = 2'd3
    } direction;

    typedef enum logic [3:0] {
        stIdle,
        stApple,
        stAppleRow,
        stBody,
        stBodyRow,
        stWait,
        stErase,
        stEraseRow,
        stCheck,
        stHitRead,
        stStep,
        stOver
    } renderState;

    typedef logic [2:0] colour;

endpackage

// ==== src/bodyIf.sv ====
//////////////////////////////////////////////////////////////////////
// Snake body bus
// Carries the segment tiles from the body register to the collision
// checker and the renderer, plus the move and check strobes.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

interface bodyIf
    import snakePkg::*;
();

    // index 0 is the head
    tilePos segment [`SNAKE_LENGTH];
    // one-cycle move command
    logic step;
    // one-cycle collision check request
    logic checkHit;
    // registered result, valid one cycle after checkHit
    logic hit;

    modport body (
        output segment,
        input  step
    );

    modport hitCheck (
        input  segment,
        input  checkHit,
        output hit
    );

    modport renderer (
        input  segment,
        input  hit,
        output step,
        output checkHit
    );

endinterface

// ==== src/frameTimer.sv ====
//////////////////////////////////////////////////////////////////////
// Animation tick generator
// Free-running counter that pulses tick for one cycle each time it
// wraps, once every 2^tickWidth clocks.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module frameTimer
#(
    parameter int tickWidth = `TICK_WIDTH
)
(
    input  logic Clock,
    input  logic reset,
    output logic tick
);

    logic [tickWidth-1:0] count;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else
        begin
            count <= count + 1'b1;
            // high in the cycle where count sits at zero again
            tick  <= (count == '1);
        end
    end

endmodule

// ==== src/snakeBody.sv ====
//////////////////////////////////////////////////////////////////////
// Snake body register
// Keeps the heading from the active-low keys and, on step, moves the
// head one tile with wrap while the body follows one place behind.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module snakeBody
    import snakePkg::*;
(
    input  logic       Clock,
    input  logic       reset,
    // active low: right, down, up, left
    input  logic [3:0] key,
    bodyIf.body        body
);

    localparam tileX lastColumn = tileX'(`SCREEN_TILES_X - 1);
    localparam tileY lastRow    = tileY'(`SCREEN_TILES_Y - 1);

    direction heading;
    tilePos   nextHead;

    // heading follows any pressed key, priority right first
    always_ff @(posedge Clock)
    begin
        if (reset)
            heading <= dirUp;
        else if (!key[0])
            heading <= dirRight;
        else if (!key[1])
            heading <= dirDown;
        else if (!key[2])
            heading <= dirUp;
        else if (!key[3])
            heading <= dirLeft;
    end

    // one tile ahead of the head, wrapping at the grid edges
    always_comb
    begin
        nextHead = body.segment[0];
        case (heading)
            dirRight:
                nextHead.x = (body.segment[0].x == lastColumn) ? '0 : body.segment[0].x + 4'd1;
            dirLeft:
                nextHead.x = (body.segment[0].x == '0) ? lastColumn : body.segment[0].x - 4'd1;
            dirDown:
                nextHead.y = (body.segment[0].y == lastRow) ? '0 : body.segment[0].y + 4'd1;
            default:
                nextHead.y = (body.segment[0].y == '0) ? lastRow : body.segment[0].y - 4'd1;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // vertical line, head on top
            for (int i = 0; i < `SNAKE_LENGTH; i++)
            begin
                body.segment[i].x <= tileX'(`START_TILE_X);
                body.segment[i].y <= tileY'(`START_TILE_Y + i);
            end
        end
        else if (body.step)
        begin
            // every segment takes its predecessor's tile
            for (int i = `SNAKE_LENGTH - 1; i > 0; i--)
            begin
                body.segment[i] <= body.segment[i-1];
            end
            body.segment[0] <= nextHead;
        end
    end

endmodule

// ==== src/collisionCheck.sv ====
//////////////////////////////////////////////////////////////////////
// Self-collision check
// On request, compares the head tile with the far body segments and
// registers the result until the next request.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module collisionCheck
(
    input  logic Clock,
    input  logic reset,
    bodyIf.hitCheck body
);

    logic headMatch;

    // nearer segments left out so a reversal is no hit
    always_comb
    begin
        headMatch = 1'b0;
        for (int i = `HIT_FIRST_SEGMENT; i < `SNAKE_LENGTH; i++)
        begin
            if (body.segment[i] == body.segment[0])
                headMatch = 1'b1;
        end
    end

    // result held between requests
    always_ff @(posedge Clock)
    begin
        if (reset)
            body.hit <= 1'b0;
        else if (body.checkHit)
            body.hit <= headMatch;
    end

endmodule

// ==== src/tileRenderer.sv ====
//////////////////////////////////////////////////////////////////////
// Frame sequencer
// Draws the apple and the body tile by tile, waits a tick, erases the
// body, checks for a self hit and then moves the snake or ends the game.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module tileRenderer
    import snakePkg::*;
(
    input  logic            Clock,
    input  logic            reset,
    input  logic            tick,
    input  logic            start,
    input  colour           bodyColour,
    bodyIf.renderer         body,
    output snakePkg::pixelX pixelX,
    output snakePkg::pixelY pixelY,
    output colour           pixelColour,
    output logic            plot,
    output logic            gameOver
);

    localparam logic [3:0] lastPixel   = 4'(`TILE_SIZE - 1);
    localparam logic [2:0] lastSegment = 3'(`SNAKE_LENGTH - 1);

    renderState state;
    // pixel column and row inside the tile
    logic [3:0] colCount;
    logic [3:0] rowCount;
    // body segment being drawn, head first
    logic [2:0] segIndex;
    tilePos     curTile;
    logic [7:0] originX;
    logic [6:0] originY;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state    <= stIdle;
            colCount <= '0;
            rowCount <= '0;
            segIndex <= '0;
        end
        else
        begin
            case (state)
                stIdle:
                    if (start && tick)
                        state <= stApple;
                // one plotted pixel per cycle along a row
                stApple, stBody, stErase:
                begin
                    if (colCount == lastPixel)
                    begin
                        colCount <= '0;
                        state    <= (state == stApple) ? stAppleRow :
                                    (state == stBody)  ? stBodyRow  : stEraseRow;
                    end
                    else
                        colCount <= colCount + 4'd1;
                end
                stAppleRow:
                begin
                    if (rowCount == lastPixel)
                    begin
                        rowCount <= '0;
                        state    <= stBody;
                    end
                    else
                    begin
                        rowCount <= rowCount + 4'd1;
                        state    <= stApple;
                    end
                end
                // next row, next segment, or end of the pass
                stBodyRow, stEraseRow:
                begin
                    if (rowCount != lastPixel)
                    begin
                        rowCount <= rowCount + 4'd1;
                        state    <= (state == stBodyRow) ? stBody : stErase;
                    end
                    else if (segIndex != lastSegment)
                    begin
                        rowCount <= '0;
                        segIndex <= segIndex + 3'd1;
                        state    <= (state == stBodyRow) ? stBody : stErase;
                    end
                    else
                    begin
                        rowCount <= '0;
                        segIndex <= '0;
                        state    <= (state == stBodyRow) ? stWait : stCheck;
                    end
                end
                stWait:
                    if (tick)
                        state <= stErase;
                stCheck:
                    state <= stHitRead;
                // hit is valid here, one cycle after checkHit
                stHitRead:
                    state <= body.hit ? stOver : stStep;
                // body positions update as the apple starts
                stStep:
                    state <= stApple;
                default:
                    state <= stOver;
            endcase
        end
    end

    // tile origin plus the position inside the tile
    always_comb
    begin
        curTile = body.segment[segIndex];
        if (state == stApple)
        begin
            originX = 8'(`APPLE_TILE_X * `TILE_SIZE);
            originY = 7'(`APPLE_TILE_Y * `TILE_SIZE);
        end
        else
        begin
            originX = 8'(curTile.x) * 8'(`TILE_SIZE);
            originY = 7'(curTile.y) * 7'(`TILE_SIZE);
        end
        pixelX = originX + 8'(colCount);
        pixelY = originY + 7'(rowCount);
    end

    always_comb
    begin
        case (state)
            stApple: pixelColour = `APPLE_COLOUR;
            stBody:  pixelColour = bodyColour;
            default: pixelColour = `ERASE_COLOUR;
        endcase
    end

    assign plot          = (state == stApple) || (state == stBody) || (state == stErase);
    assign gameOver      = (state == stOver);
    assign body.checkHit = (state == stCheck);
    assign body.step     = (state == stStep);

endmodule

// ==== src/snakeGame.sv ====
//////////////////////////////////////////////////////////////////////
// Snake game top level
// Ties the tick timer, body register, collision check and frame
// sequencer together and drives the frame buffer write port.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module snakeGame
    import snakePkg::*;
#(
    // small values speed up the animation in simulation
    parameter int tickWidth = `TICK_WIDTH
)
(
    input  logic            Clock,
    input  logic            reset,
    // active low: right, down, up, left
    input  logic [3:0]      key,
    input  logic            start,
    input  colour           bodyColour,
    output snakePkg::pixelX pixelX,
    output snakePkg::pixelY pixelY,
    output colour           pixelColour,
    output logic            plot,
    output logic            gameOver
);

    logic tick;

    // body tiles and move/check strobes shared by the inner blocks
    bodyIf bodyBus ();

    frameTimer #(
        .tickWidth(tickWidth)
    ) frameTimerInst (
        .Clock(Clock),
        .reset(reset),
        .tick (tick)
    );

    snakeBody snakeBodyInst (
        .Clock(Clock),
        .reset(reset),
        .key  (key),
        .body (bodyBus.body)
    );

    collisionCheck collisionCheckInst (
        .Clock(Clock),
        .reset(reset),
        .body (bodyBus.hitCheck)
    );

    tileRenderer tileRendererInst (
        .Clock      (Clock),
        .reset      (reset),
        .tick       (tick),
        .start      (start),
        .bodyColour (bodyColour),
        .body       (bodyBus.renderer),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColour(pixelColour),
        .plot       (plot),
        .gameOver   (gameOver)
    );

endmodule

// ==== sim/tb_snakeGame.sv ====
//////////////////////////////////////////////////////////////////////
// Snake game testbench
// Drives random and directed keys into the snake game, rebuilds each
// frame's pixel order in a reference model and compares every plotted
// pixel, the game over flag and the idle behaviour after reset.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "snake_cfg.svh"

module tb_snakeGame;

    localparam int simTickWidth   = 4;
    localparam int tickCycles     = 1 << simTickWidth;
    localparam int frameLimit     = 40;
    localparam int renderCycles   = 2000;
    localparam int cycleLimit     = frameLimit * (tickCycles + renderCycles);
    localparam int randomFrames   = 30;
    localparam int directedFrames = 8;
    // model heading codes
    localparam int headRight = 0;
    localparam int headDown  = 1;
    localparam int headUp    = 2;
    localparam int headLeft  = 3;

    logic       Clock;
    logic       reset;
    logic [3:0] key;
    logic       start;
    logic [2:0] bodyColour;
    logic [7:0] pixelX;
    logic [6:0] pixelY;
    logic [2:0] pixelColour;
    logic       plot;
    logic       gameOver;

    int          errorCount;
    int          frameCount;
    int          cycleCount = 0;
    integer      seed;
    logic [31:0] colourPick;
    // plotted pixels in order, {x, y, colour}
    logic [17:0] pixelQueue [$];
    // active low: right, down, left, up
    logic [3:0]  turnKeys [4] = '{4'b1110, 4'b1101, 4'b0111, 4'b1011};

    // reference model of the body
    int modelX [`SNAKE_LENGTH];
    int modelY [`SNAKE_LENGTH];
    int modelHeading;
    bit modelOver;

    snakeGame #(
        .tickWidth(simTickWidth)
    ) snakeGame_inst (
        .Clock      (Clock),
        .reset      (reset),
        .key        (key),
        .start      (start),
        .bodyColour (bodyColour),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColour(pixelColour),
        .plot       (plot),
        .gameOver   (gameOver)
    );

    always #2 Clock = ~Clock;

    // pixel monitor, mid-cycle sample
    always @(negedge Clock)
    begin
        if (plot === 1'b1)
            pixelQueue.push_back({pixelX, pixelY, pixelColour});
    end

    always @(posedge Clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Error: run stopped after %0d cycles without finishing the frames",
                     cycleCount);
            $display("Checks finished with %0d errors over %0d frames",
                     errorCount + 1, frameCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("Mismatch in %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic reportError(input string text);
        errorCount++;
        $display("Error: %s", text);
    endtask

    function automatic void resetModel();
        // vertical line below the start tile
        for (int i = 0; i < `SNAKE_LENGTH; i++)
        begin
            modelX[i] = `START_TILE_X;
            modelY[i] = `START_TILE_Y + i;
        end
        modelHeading = headUp;
        modelOver    = 1'b0;
    endfunction

    // key priority right, down, up, left; none keeps the heading
    function automatic void updateHeading(input logic [3:0] keys);
        if (!keys[0])
            modelHeading = headRight;
        else if (!keys[1])
            modelHeading = headDown;
        else if (!keys[2])
            modelHeading = headUp;
        else if (!keys[3])
            modelHeading = headLeft;
    endfunction

    function automatic void stepModel();
        for (int i = `SNAKE_LENGTH - 1; i > 0; i--)
        begin
            modelX[i] = modelX[i-1];
            modelY[i] = modelY[i-1];
        end
        // one tile ahead, wrapping at the grid edges
        case (modelHeading)
            headRight: modelX[0] = (modelX[0] + 1) % `SCREEN_TILES_X;
            headLeft:  modelX[0] = (modelX[0] + `SCREEN_TILES_X - 1) % `SCREEN_TILES_X;
            headDown:  modelY[0] = (modelY[0] + 1) % `SCREEN_TILES_Y;
            default:   modelY[0] = (modelY[0] + `SCREEN_TILES_Y - 1) % `SCREEN_TILES_Y;
        endcase
    endfunction

    function automatic bit headHit();
        for (int i = `HIT_FIRST_SEGMENT; i < `SNAKE_LENGTH; i++)
        begin
            if (modelX[i] == modelX[0] && modelY[i] == modelY[0])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // about one frame in four with no key pressed
    function automatic logic [3:0] randomKey();
        logic [31:0] r;
        r = $random(seed);
        if (r[5:4] == 2'b00)
            return 4'hF;
        return r[3:0];
    endfunction

    task automatic waitPixel();
        while (pixelQueue.size() == 0)
            @(posedge Clock);
    endtask

    // 100 pixels of one tile, row by row, left to right
    task automatic checkTile(input string label, input int tileCol, input int tileRow,
                             input logic [2:0] expColour);
        logic [17:0] pix;
        for (int row = 0; row < `TILE_SIZE; row++)
        begin
            for (int col = 0; col < `TILE_SIZE; col++)
            begin
                waitPixel();
                pix = pixelQueue.pop_front();
                checkValue({label, " x"}, tileCol * `TILE_SIZE + col, 32'(pix[17:10]));
                checkValue({label, " y"}, tileRow * `TILE_SIZE + row, 32'(pix[9:3]));
                checkValue({label, " colour"}, 32'(expColour), 32'(pix[2:0]));
            end
        end
    endtask

    task automatic applyReset();
        // already held from time zero on the first call
        if (reset !== 1'b1)
        begin
            @(posedge Clock);
            reset <= 1'b1;
            key   <= 4'hF;
        end
        repeat (5) @(posedge Clock);
        reset <= 1'b0;
        pixelQueue.delete();
        @(negedge Clock);
        checkValue("reset plot", 0, 32'(plot));
        checkValue("reset gameOver", 0, 32'(gameOver));
        resetModel();
    endtask

    task automatic waitGameOver(input string tag);
        int waited;
        waited = 0;
        while ((gameOver !== 1'b1) && (waited < 16))
        begin
            @(negedge Clock);
            waited++;
        end
        if (gameOver !== 1'b1)
            reportError({"gameOver did not rise after the colliding ", tag});
        // nothing more is drawn until reset
        repeat (3 * tickCycles)
        begin
            @(negedge Clock);
            checkValue({tag, " plot after game over"}, 0, 32'(plot));
            checkValue({tag, " gameOver hold"}, 1, 32'(gameOver));
        end
        checkValue({tag, " pixels after game over"}, 0, 32'(pixelQueue.size()));
    endtask

    task automatic checkFrame(input logic [3:0] frameKey);
        string tag;
        tag = $sformatf("frame %0d", frameCount);
        waitPixel();
        // keys change once the apple starts, held for the frame
        @(posedge Clock);
        key <= frameKey;
        checkTile({tag, " apple"}, `APPLE_TILE_X, `APPLE_TILE_Y, `APPLE_COLOUR);
        for (int i = 0; i < `SNAKE_LENGTH; i++)
            checkTile($sformatf("%s body %0d", tag, i), modelX[i], modelY[i], bodyColour);
        for (int i = 0; i < `SNAKE_LENGTH; i++)
            checkTile($sformatf("%s erase %0d", tag, i), modelX[i], modelY[i], `ERASE_COLOUR);
        updateHeading(frameKey);
        if (headHit())
        begin
            modelOver = 1'b1;
            waitGameOver(tag);
        end
        else
        begin
            repeat (8)
            begin
                @(negedge Clock);
                checkValue({tag, " gameOver"}, 0, 32'(gameOver));
            end
            stepModel();
        end
        frameCount++;
    endtask

    initial
    begin
        Clock      = 1'b0;
        reset      = 1'b1;
        key        = 4'hF;
        start      = 1'b0;
        bodyColour = 3'b010;
        errorCount = 0;
        frameCount = 0;
        seed       = 32'heff9;

        // no drawing while start is low
        applyReset();
        repeat (5 * tickCycles)
        begin
            @(negedge Clock);
            checkValue("idle plot", 0, 32'(plot));
            checkValue("idle gameOver", 0, 32'(gameOver));
        end
        checkValue("idle pixels", 0, 32'(pixelQueue.size()));

        // random keys over many frames
        colourPick = $random(seed);
        @(posedge Clock);
        start      <= 1'b1;
        bodyColour <= colourPick[2:0] | 3'b001;
        for (int f = 0; f < randomFrames && !modelOver; f++)
            checkFrame(randomKey());

        // turn back into the body from the start position
        applyReset();
        for (int f = 0; f < directedFrames && !modelOver; f++)
            checkFrame(turnKeys[f % 4]);
        if (!modelOver)
            reportError("directed turn sequence never reached a collision");

        $display("Checks finished with %0d errors over %0d frames", errorCount, frameCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/snakePkg.sv
src/bodyIf.sv
src/frameTimer.sv
src/snakeBody.sv
src/collisionCheck.sv
src/tileRenderer.sv
src/snakeGame.sv
sim/tb_snakeGame.sv

// ==== Makefile ====
# Verilator build and run for the snake game testbench
VERILATOR ?= verilator
TOP       ?= tb_snakeGame
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/snake_cfg.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
